// ==== logic/cache_l1.sv ====
`timescale 1ns/10ps
`include "core_defs.svh"

module cache_l1 #(
    parameter int lines = `cache_lines
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      enable,
    input  logic                      clear,
    input  structures::xlen_t         addr,
    output structures::xlen_t         rdata,
    output logic                      miss,
    output structures::mem_bus_req_t  req,
    input  structures::mem_bus_resp_t resp
);
    localparam int index_bits = $clog2(lines);
    localparam int tag_bits = 64 - 3 - index_bits;

    structures::xlen_t line_data [lines];
    logic [tag_bits-1:0] line_tag [lines];
    logic [lines-1:0] line_valid;

    structures::xlen_t addr_q;
    logic lookup_q;  // Registered address belongs to a live fetch
    logic [index_bits-1:0] index;
    logic [tag_bits-1:0] tag;
    logic fill;

    always_comb begin
        index = addr_q[3 +: index_bits];
        tag = addr_q[63 -: tag_bits];
        miss = lookup_q && !(line_valid[index] && line_tag[index] == tag);
        req.valid = miss && !clear;  // A flush abandons the refill
        req.addr = {addr_q[63:3], 3'b000};
        fill = req.valid && resp.mem_ready;
        rdata = fill ? resp.data : line_data[index];  // Refill data bypasses the array
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            addr_q <= '0;
            lookup_q <= 1'b0;
            line_valid <= '0;
        end else begin
            if (enable || clear) begin
                addr_q <= addr;
                lookup_q <= !clear;  // Wrong-path address never requests a line
            end
            if (fill) begin
                line_valid[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            line_data[index] <= resp.data;
            line_tag[index] <= tag;
        end
    end

endmodule

// ==== logic/core_defs.svh ====
`ifndef core_defs_svh
`define core_defs_svh

// Address of the first instruction fetched after reset
`define core_reset_pc 64'h100

// Number of 8-byte instruction cache lines, a power of two
`define cache_lines 16

`endif

// ==== logic/core_ex.sv ====
`timescale 1ns/10ps

module core_ex (
    input  logic                 clock,
    input  logic                 reset,
    input  structures::id_regs_t id_regs,
    input  structures::xlen_t    first_half_pc4,
    output structures::xlen_t    next_fetch_pc,
    output logic                 flush,
    output structures::ex_regs_t ex_fwd,
    output structures::ex_regs_t ex_regs
);
    structures::xlen_t result;
    logic taken;
    structures::ex_regs_t ex_q;
    logic ex_valid_q;

    always_comb begin
        case (id_regs.alu_op)
            structures::alu_add: result = id_regs.op_a + id_regs.op_b;
            structures::alu_sub: result = id_regs.op_a - id_regs.op_b;
            structures::alu_and: result = id_regs.op_a & id_regs.op_b;
            structures::alu_or: result = id_regs.op_a | id_regs.op_b;
            structures::alu_xor: result = id_regs.op_a ^ id_regs.op_b;
            structures::alu_pass_b: result = id_regs.op_b;
            default: result = '0;
        endcase

        case (id_regs.branch)
            structures::br_beq: taken = id_regs.rs1_val == id_regs.rs2_val;
            structures::br_bne: taken = id_regs.rs1_val != id_regs.rs2_val;
            structures::br_jal: taken = 1'b1;
            default: taken = 1'b0;
        endcase

        flush = id_regs.valid && taken;  // Kills the two younger fetches
        next_fetch_pc = flush ? id_regs.target : first_half_pc4;

        ex_fwd.valid = id_regs.valid;
        ex_fwd.pc = id_regs.pc;
        ex_fwd.rd = id_regs.rd;
        ex_fwd.value = (id_regs.rd == '0) ? '0 : result;  // Branches carry rd x0
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= ex_fwd.valid;
        end
    end

    always_ff @(posedge clock) begin
        ex_q <= ex_fwd;
    end

    always_comb begin
        ex_regs = ex_q;
        ex_regs.valid = ex_valid_q;
    end

endmodule

// ==== logic/core_id.sv ====
`timescale 1ns/10ps

module core_id (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  flush,
    input  structures::if_regs_t  if_regs,
    input  structures::ex_regs_t  ex_fwd,
    input  structures::xlen_t     rs1_data,
    input  structures::xlen_t     rs2_data,
    output structures::reg_idx_t  rs1_idx,
    output structures::reg_idx_t  rs2_idx,
    output structures::id_regs_t  id_regs
);
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal = 7'b1101111;

    structures::inst_t inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    structures::xlen_t imm_i;
    structures::xlen_t imm_u;
    structures::xlen_t imm_b;
    structures::xlen_t imm_j;
    structures::id_regs_t decoded;
    structures::id_regs_t id_q;
    logic id_valid_q;

    // Result of the instruction in execute wins over the register file
    function automatic structures::xlen_t pick_src(
        input structures::reg_idx_t idx,
        input structures::xlen_t rf_value,
        input structures::ex_regs_t fwd
    );
        if (fwd.valid && fwd.rd == idx && idx != '0) begin
            return fwd.value;
        end
        return rf_value;
    endfunction

    always_comb begin
        inst = if_regs.inst;
        opcode = inst[6:0];
        funct3 = inst[14:12];
        funct7 = inst[31:25];
        rs1_idx = inst[19:15];
        rs2_idx = inst[24:20];

        imm_i = {{52{inst[31]}}, inst[31:20]};
        imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};  // LUI result is sign-extended
        imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

        decoded.valid = if_regs.valid && !flush;
        decoded.pc = if_regs.fetch_pc;
        decoded.pc4 = if_regs.fetch_pc4;
        decoded.rd = '0;  // Anything outside the subset writes nothing
        decoded.alu_op = structures::alu_add;
        decoded.branch = structures::br_none;
        decoded.rs1_val = pick_src(rs1_idx, rs1_data, ex_fwd);
        decoded.rs2_val = pick_src(rs2_idx, rs2_data, ex_fwd);
        decoded.op_a = decoded.rs1_val;
        decoded.op_b = decoded.rs2_val;
        decoded.target = if_regs.fetch_pc + imm_b;

        case (opcode)
            opc_op_imm: begin
                if (funct3 == 3'b000) begin
                    decoded.rd = inst[11:7];
                    decoded.op_b = imm_i;
                end
            end
            opc_op: begin
                decoded.rd = inst[11:7];
                case (funct3)
                    3'b000: decoded.alu_op = funct7[5] ? structures::alu_sub
                                                       : structures::alu_add;
                    3'b100: decoded.alu_op = structures::alu_xor;
                    3'b110: decoded.alu_op = structures::alu_or;
                    3'b111: decoded.alu_op = structures::alu_and;
                    default: decoded.rd = '0;
                endcase
            end
            opc_lui: begin
                decoded.rd = inst[11:7];
                decoded.alu_op = structures::alu_pass_b;
                decoded.op_a = '0;
                decoded.op_b = imm_u;
            end
            opc_branch: begin
                if (funct3 == 3'b000) begin
                    decoded.branch = structures::br_beq;
                end else if (funct3 == 3'b001) begin
                    decoded.branch = structures::br_bne;
                end
            end
            opc_jal: begin
                decoded.rd = inst[11:7];
                decoded.branch = structures::br_jal;
                decoded.op_a = if_regs.fetch_pc;
                decoded.op_b = 64'd4;  // Link value comes out of the adder
                decoded.target = if_regs.fetch_pc + imm_j;
            end
            default: begin
                decoded.rd = '0;
            end
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            id_valid_q <= 1'b0;
        end else begin
            id_valid_q <= decoded.valid;
        end
    end

    always_ff @(posedge clock) begin
        id_q <= decoded;
    end

    always_comb begin
        id_regs = id_q;
        id_regs.valid = id_valid_q;
    end

endmodule

// ==== logic/core_if.sv ====
`timescale 1ns/10ps
`include "core_defs.svh"

module core_if #(
    parameter structures::xlen_t reset_pc = `core_reset_pc
) (
    input  logic                      clock,
    input  logic                      reset,
    input  structures::xlen_t         next_fetch_pc,
    input  logic                      flush,
    output structures::xlen_t         first_half_pc4,
    output structures::if_regs_t      if_regs,
    output structures::mem_bus_req_t  inst_req,
    input  structures::mem_bus_resp_t inst_resp
);
    structures::xlen_t fetch_pc;
    structures::xlen_t fetch_pc4;
    structures::xlen_t if_pc;
    structures::xlen_t if_pc4;
    structures::xlen_t line;
    logic if_valid_q;
    logic miss;
    logic miss_stall;
    logic advance;

    cache_l1 inst_cache (
        .clock(clock),
        .reset(reset),
        .enable(!miss_stall),
        .clear(flush),
        .addr(fetch_pc),
        .rdata(line),
        .miss(miss),
        .req(inst_req),
        .resp(inst_resp)
    );

    always_comb begin
        miss_stall = miss && !inst_resp.mem_ready;  // Refill cycle lets fetch move on
        advance = !miss_stall || flush;
        first_half_pc4 = fetch_pc4;
        if_regs.valid = if_valid_q && !miss_stall;
        if_regs.fetch_pc = if_pc;
        if_regs.fetch_pc4 = if_pc4;
        if_regs.inst = if_pc[2] ? line[63:32] : line[31:0];
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            fetch_pc <= reset_pc;
            fetch_pc4 <= reset_pc + 64'd4;
            if_valid_q <= 1'b0;
        end else if (advance) begin
            fetch_pc <= next_fetch_pc;
            fetch_pc4 <= next_fetch_pc + 64'd4;
            if_valid_q <= !flush;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            if_pc <= fetch_pc;
            if_pc4 <= fetch_pc4;
        end
    end

endmodule

// ==== logic/core_top.sv ====
`timescale 1ns/10ps

module core_top (
    input  logic                      clock,
    input  logic                      reset,
    output structures::mem_bus_req_t  inst_req,
    input  structures::mem_bus_resp_t inst_resp,
    output structures::ex_regs_t      retire
);
    structures::xlen_t next_fetch_pc;
    structures::xlen_t first_half_pc4;
    logic flush;
    structures::if_regs_t if_regs;
    structures::reg_idx_t rs1_idx;
    structures::reg_idx_t rs2_idx;
    structures::xlen_t rs1_data;
    structures::xlen_t rs2_data;
    structures::id_regs_t id_regs;
    structures::ex_regs_t ex_fwd;
    structures::ex_regs_t ex_regs;

    core_if if_i (
        .clock(clock),
        .reset(reset),
        .next_fetch_pc(next_fetch_pc),
        .flush(flush),
        .first_half_pc4(first_half_pc4),
        .if_regs(if_regs),
        .inst_req(inst_req),
        .inst_resp(inst_resp)
    );

    core_id id_i (
        .clock(clock),
        .reset(reset),
        .flush(flush),
        .if_regs(if_regs),
        .ex_fwd(ex_fwd),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .id_regs(id_regs)
    );

    core_ex ex_i (
        .clock(clock),
        .reset(reset),
        .id_regs(id_regs),
        .first_half_pc4(first_half_pc4),
        .next_fetch_pc(next_fetch_pc),
        .flush(flush),
        .ex_fwd(ex_fwd),
        .ex_regs(ex_regs)
    );

    core_wb wb_i (
        .clock(clock),
        .reset(reset),
        .ex_regs(ex_regs),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .retire(retire)
    );

endmodule

// ==== logic/core_wb.sv ====
`timescale 1ns/10ps

module core_wb (
    input  logic                 clock,
    input  logic                 reset,
    input  structures::ex_regs_t ex_regs,
    input  structures::reg_idx_t rs1_idx,
    input  structures::reg_idx_t rs2_idx,
    output structures::xlen_t    rs1_data,
    output structures::xlen_t    rs2_data,
    output structures::ex_regs_t retire
);
    structures::xlen_t regs [31:1];  // No storage behind x0
    structures::ex_regs_t retire_q;
    logic retire_valid_q;

    // Same-cycle write is visible to decode
    function automatic structures::xlen_t read_port(
        input structures::reg_idx_t idx,
        input structures::xlen_t stored,
        input structures::ex_regs_t wr
    );
        if (idx == '0) begin
            return '0;
        end
        if (wr.valid && wr.rd == idx) begin
            return wr.value;
        end
        return stored;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx, regs[rs1_idx], ex_regs);
        rs2_data = read_port(rs2_idx, regs[rs2_idx], ex_regs);
    end

    always_ff @(posedge clock) begin
        if (ex_regs.valid && ex_regs.rd != '0) begin
            regs[ex_regs.rd] <= ex_regs.value;
        end
        retire_q <= ex_regs;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            retire_valid_q <= 1'b0;
        end else begin
            retire_valid_q <= ex_regs.valid;
        end
    end

    always_comb begin
        retire = retire_q;
        retire.valid = retire_valid_q;
    end

endmodule

// ==== logic/structures.sv ====
package structures;

    typedef logic [63:0] xlen_t;  // Data word or byte address
    typedef logic [31:0] inst_t;
    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic valid;
        xlen_t addr;  // Always aligned to a whole line
    } mem_bus_req_t;

    typedef struct packed {
        logic mem_ready;
        xlen_t data;  // The whole 64-bit line
    } mem_bus_resp_t;

    typedef struct packed {
        logic valid;
        xlen_t fetch_pc;
        xlen_t fetch_pc4;
        inst_t inst;
    } if_regs_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jal
    } branch_kind_t;

    typedef struct packed {
        logic valid;
        xlen_t pc;
        xlen_t pc4;
        reg_idx_t rd;
        alu_op_t alu_op;
        branch_kind_t branch;
        xlen_t op_a;
        xlen_t op_b;
        xlen_t rs1_val;
        xlen_t rs2_val;
        xlen_t target;  // PC plus the branch or jump offset
    } id_regs_t;

    // value is kept at zero whenever rd is x0
    typedef struct packed {
        logic valid;
        xlen_t pc;
        reg_idx_t rd;
        xlen_t value;
    } ex_regs_t;

endpackage

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module core_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vcore_tb)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation returned status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Test OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb.f ====
+incdir+logic
+incdir+tests
logic/structures.sv
logic/cache_l1.sv
logic/core_if.sv
logic/core_id.sv
logic/core_ex.sv
logic/core_wb.sv
logic/core_top.sv
tests/core_tb.sv

// ==== tests/core_program.svh ====
`ifndef core_program_svh
`define core_program_svh

localparam int image_words = 80;
localparam int random_first = 11;
localparam int final_index = 71;  // JAL x0 to itself
localparam logic [31:0] nop_inst = 32'h00000013;  // ADDI x0, x0, 0
localparam structures::xlen_t final_pc = `core_reset_pc + 64'(4 * final_index);

logic [31:0] image [image_words];
logic [31:0] rng_state = 32'hd367b7f9;
structures::xlen_t model_pc;
structures::xlen_t model_regs [32];

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic int unsigned random_below(input int unsigned limit);
    rng_state = xorshift32(rng_state);
    return rng_state % limit;
endfunction

function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] alu_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] branch_word(input logic [2:0] funct3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

task automatic build_program();
    int idx;
    int kind;
    int skip;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (idx = 0; idx < image_words; idx++) begin
        image[idx] = nop_inst;
    end
    for (idx = 0; idx < 6; idx++) begin
        image[idx] = addi_word(5'(idx + 2), 5'd0, 12'(random_below(4096)));  // Seeds x2 to x7
    end
    image[6] = addi_word(5'd1, 5'd0, 12'd3);
    image[7] = addi_word(5'd2, 5'd2, 12'd7);  // Loop body starts here
    image[8] = alu_word(7'b0000000, 3'b000, 5'd3, 5'd3, 5'd2);
    image[9] = addi_word(5'd1, 5'd1, 12'hfff);
    image[10] = branch_word(3'b001, 5'd1, 5'd0, 13'h1ff4);  // BNE back by three instructions
    for (idx = random_first; idx < final_index; idx++) begin
        kind = int'(random_below(10));
        rd = 5'(random_below(8));
        rs1 = 5'(random_below(8));
        rs2 = 5'(random_below(8));
        skip = 2 + int'(random_below(4));
        if (idx + skip > final_index) begin
            skip = final_index - idx;
        end
        case (kind)
            0: image[idx] = addi_word(rd, rs1, 12'(random_below(4096)));
            1: image[idx] = alu_word(7'b0000000, 3'b000, rd, rs1, rs2);
            2: image[idx] = alu_word(7'b0100000, 3'b000, rd, rs1, rs2);  // SUB
            3: image[idx] = alu_word(7'b0000000, 3'b111, rd, rs1, rs2);
            4: image[idx] = alu_word(7'b0000000, 3'b110, rd, rs1, rs2);
            5: image[idx] = alu_word(7'b0000000, 3'b100, rd, rs1, rs2);
            6: image[idx] = {20'(random_below(1 << 20)), rd, 7'b0110111};  // LUI
            7: image[idx] = branch_word(3'b000, rs1, rs2, 13'(skip * 4));
            8: image[idx] = branch_word(3'b001, rs1, rs2, 13'(skip * 4));
            default: image[idx] = jal_word(rd, 21'(skip * 4));
        endcase
    end
    image[final_index] = jal_word(5'd0, 21'd0);
endtask

function automatic logic [31:0] word_at(input structures::xlen_t addr);
    structures::xlen_t offset;
    offset = addr - `core_reset_pc;
    if (addr < `core_reset_pc || offset >= 64'(4 * image_words)) begin
        return nop_inst;
    end
    return image[int'(offset >> 2)];
endfunction

// Executes one instruction on the architectural model
function automatic structures::ex_regs_t step_model();
    structures::ex_regs_t rec;
    logic [31:0] inst;
    logic [4:0] rd;
    structures::xlen_t rs1_val;
    structures::xlen_t rs2_val;
    structures::xlen_t value;
    structures::xlen_t next_pc;
    inst = word_at(model_pc);
    rd = inst[11:7];
    rs1_val = model_regs[inst[19:15]];
    rs2_val = model_regs[inst[24:20]];
    value = '0;
    next_pc = model_pc + 64'd4;
    case (inst[6:0])
        7'b0010011: value = rs1_val + {{52{inst[31]}}, inst[31:20]};
        7'b0110011: begin
            case (inst[14:12])
                3'b000: value = inst[30] ? rs1_val - rs2_val : rs1_val + rs2_val;
                3'b100: value = rs1_val ^ rs2_val;
                3'b110: value = rs1_val | rs2_val;
                default: value = rs1_val & rs2_val;
            endcase
        end
        7'b0110111: value = {{32{inst[31]}}, inst[31:12], 12'b0};
        7'b1100011: begin
            rd = 5'd0;
            if ((rs1_val == rs2_val) == (inst[14:12] == 3'b000)) begin
                next_pc = model_pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25],
                                      inst[11:8], 1'b0};
            end
        end
        7'b1101111: begin
            value = model_pc + 64'd4;
            next_pc = model_pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20],
                                  inst[30:21], 1'b0};
        end
        default: rd = 5'd0;
    endcase
    if (rd == 5'd0) begin
        value = '0;
    end else begin
        model_regs[rd] = value;
    end
    rec.valid = 1'b1;
    rec.pc = model_pc;
    rec.rd = rd;
    rec.value = value;
    model_pc = next_pc;
    return rec;
endfunction

function automatic void reset_model();
    int r;
    model_pc = `core_reset_pc;
    for (r = 0; r < 32; r++) begin
        model_regs[r] = '0;
    end
endfunction

function automatic int count_retirements();
    structures::ex_regs_t rec;
    int count;
    reset_model();
    rec = '0;
    count = 0;
    while (rec.pc != final_pc && count < 10000) begin
        rec = step_model();
        count++;
    end
    reset_model();
    return count;
endfunction

`endif

// ==== tests/core_tb.sv ====
`timescale 1ns/10ps
`include "core_defs.svh"

module core_tb;
    logic clock;
    logic reset;
    structures::mem_bus_req_t inst_req;
    structures::mem_bus_resp_t inst_resp;
    structures::ex_regs_t retire;
    int expected_retires = 0;

    `include "core_program.svh"

    core_top dut_i (
        .clock(clock),
        .reset(reset),
        .inst_req(inst_req),
        .inst_resp(inst_resp),
        .retire(retire)
    );

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_field(input string name, input structures::xlen_t expected,
                                 input structures::xlen_t actual);
        assert (actual == expected) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_request(input logic first);
        structures::xlen_t addr;
        addr = inst_req.addr;
        if (first) begin
            compare_field("first fetch address", `core_reset_pc & ~64'h7, addr);
        end
        assert (addr[2:0] == 3'b000) else begin
            $display("Fetch request address %h is not aligned to 8 bytes", addr);
            stop_with_failure();
        end
        assert (addr >= `core_reset_pc && addr < `core_reset_pc + 64'(4 * image_words)) else begin
            $display("Fetch request address %h lies outside the program image", addr);
            stop_with_failure();
        end
    endtask

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    initial begin : memory_model
        structures::xlen_t pending_addr;
        int wait_left;
        logic busy;
        inst_resp <= '0;
        pending_addr = '0;
        wait_left = 0;
        busy = 1'b0;
        forever begin
            @(posedge clock);
            if (reset || !inst_req.valid || inst_resp.mem_ready) begin
                inst_resp.mem_ready <= 1'b0;  // Strobe lasts one cycle
                busy = 1'b0;
            end else begin
                if (!busy || inst_req.addr != pending_addr) begin
                    pending_addr = inst_req.addr;  // New or moved request restarts the delay
                    wait_left = 1 + int'(random_below(4));
                    busy = 1'b1;
                end
                wait_left--;
                if (wait_left == 0) begin
                    inst_resp.mem_ready <= 1'b1;
                    inst_resp.data <= {word_at(pending_addr + 64'd4), word_at(pending_addr)};
                    busy = 1'b0;
                end
            end
        end
    end

    initial begin : check_retire
        structures::ex_regs_t expected;
        int retired;
        logic first_request;
        logic done;
        reset <= 1'b1;
        expected = '0;
        retired = 0;
        first_request = 1'b1;
        done = 1'b0;
        build_program();
        expected_retires = count_retirements();
        repeat (4) begin
            @(posedge clock);
            assert (!retire.valid && !inst_req.valid) else begin
                $display("Retire or fetch request was active during reset");
                stop_with_failure();
            end
        end
        reset <= 1'b0;
        while (!done) begin
            @(posedge clock);
            if (inst_req.valid) begin
                check_request(first_request);
                first_request = 1'b0;
            end
            if (retire.valid) begin
                expected = step_model();
                retired++;
                compare_field($sformatf("retire %0d pc", retired), expected.pc, retire.pc);
                compare_field($sformatf("retire %0d rd", retired), 64'(expected.rd),
                              64'(retire.rd));
                compare_field($sformatf("retire %0d value", retired), expected.value,
                              retire.value);
                done = expected.pc == final_pc;  // Self-loop reached
            end
        end
        $display("Test OK");
        $finish;
    end

    initial begin : watchdog
        wait (expected_retires != 0);
        repeat (100 + 25 * expected_retires) @(posedge clock);
        $display("Watchdog expired because the core stopped retiring instructions");
        stop_with_failure();
    end

endmodule
